/* design/fetch_macros.svh */
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// word and address width of the core
`define XLEN 32

// block size of the instruction memory, in bits
`define BLOCK_BITS 64

// branch target buffer holds 2**4 = 16 entries
`define BTB_INDEX_BITS 4

// instruction cache holds 2**5 = 32 blocks of 8 bytes
`define ICACHE_INDEX_BITS 5

// fetch queue toward decode
`define FETCH_QUEUE_DEPTH 4

`endif

/* design/fetch_pkg.sv */
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

	// data memory bus command, anything but none blocks fetch
	typedef enum logic [1:0] {
		bus_none  = 2'h0,
		bus_load  = 2'h1,
		bus_store = 2'h2
	} mem_command_t;

	// packet from fetch into the queue and on to decode
	typedef struct packed {
		logic             valid; // packet holds a real instruction
		logic [`XLEN-1:0] inst;  // 32-bit instruction word
		logic [`XLEN-1:0] pc;    // pc of inst
		logic [`XLEN-1:0] npc;   // predicted next pc
	} if_id_packet_t;

	// target buffer answer for the current pc
	typedef struct packed {
		logic             valid;      // tag hit
		logic             prediction; // counter high bit, 1 = taken
		logic [`XLEN-1:0] target_pc;
	} btb_lookup_t;

	// resolved branch coming back from retire
	typedef struct packed {
		logic             valid;
		logic [`XLEN-1:0] pc;
		logic             taken;
		logic [`XLEN-1:0] target_pc;
	} btb_update_t;

	// lookup request from fetch
	typedef struct packed {
		logic             valid;
		logic [`XLEN-1:0] pc;
	} fetch_btb_t;

	////////////////////////////////
	// refill port toward external memory
	////////////////////////////////

	typedef struct packed {
		logic             valid; // one-cycle request strobe
		logic [`XLEN-1:0] addr;  // block address, low 3 bits zero
	} mem_request_t;

	typedef struct packed {
		logic                   valid; // one-cycle response strobe
		logic [`BLOCK_BITS-1:0] data;  // whole block
	} mem_response_t;

endpackage

`default_nettype wire

/* design/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_stage import fetch_pkg::*; (
	input  wire logic                   clock,
	input  wire logic                   reset,
	input  wire logic                   squash,       // retire redirect, level
	input  wire logic [`XLEN-1:0]       rt_npc,       // redirect target
	input  wire logic                   stall,        // queue full
	input  wire mem_command_t           dmem_command, // data bus busy blocks fetch
	input  wire logic [`BLOCK_BITS-1:0] icache_data,
	input  wire logic                   icache_hit,
	input  wire btb_lookup_t            btb_lookup,
	output logic [`XLEN-1:0]            icache_addr,
	output if_id_packet_t               if_packet,
	output fetch_btb_t                  btb_request
);

	logic [`XLEN-1:0] pc;         // pc being fetched this cycle
	logic [`XLEN-1:0] pc_plus_4;
	logic [`XLEN-1:0] npc;        // predicted next pc
	logic             fetch_ok;   // packet goes into the queue this cycle
	logic             take_pred;

	//////////////////////////////
	// cache and btb requests
	//////////////////////////////

	assign icache_addr = {pc[`XLEN-1:3], 3'b000}; // block aligned

	assign btb_request.valid = fetch_ok;
	assign btb_request.pc    = pc;

	//////////////////////////////
	// next pc
	//////////////////////////////

	assign pc_plus_4 = pc + `XLEN'd4;
	assign take_pred = btb_lookup.valid && btb_lookup.prediction; // hit and counter says taken
	assign npc       = take_pred ? btb_lookup.target_pc : pc_plus_4;

	// fetch only when the data bus is idle, the queue has room and the block is present
	assign fetch_ok = (dmem_command == bus_none) && !stall && icache_hit;

	//////////////////////////////
	// outgoing packet
	//////////////////////////////

	always_comb begin
		if_packet.valid = fetch_ok;
		// pc bit 2 picks the upper word of the block
		if (pc[2]) begin
			if_packet.inst = icache_data[63:32];
		end else begin
			if_packet.inst = icache_data[31:0];
		end
		if_packet.pc  = pc;
		if_packet.npc = npc;
	end

	// pc register, squash wins over advancing
	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= '0;          // boot at address 0
		end else if (squash) begin
			pc <= rt_npc;      // redirect from retire
		end else if (fetch_ok) begin
			pc <= npc;
		end
	end

endmodule

`default_nettype wire

/* design/branch_target_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module branch_target_buffer import fetch_pkg::*; (
	input  wire logic  clock,
	input  wire logic  reset,
	input  wire fetch_btb_t  btb_request,
	input  wire btb_update_t btb_update,
	output btb_lookup_t      btb_lookup
);

	localparam int ENTRIES  = 1 << `BTB_INDEX_BITS;
	localparam int TAG_BITS = `XLEN - `BTB_INDEX_BITS - 2; // above index and word offset

	// entry storage
	logic                   entry_valid  [ENTRIES];
	logic [TAG_BITS-1:0]    entry_tag    [ENTRIES];
	logic [`XLEN-1:0]       entry_target [ENTRIES];
	logic [1:0]             entry_count  [ENTRIES]; // 2-bit saturating counter

	logic [`BTB_INDEX_BITS-1:0] rd_index;
	logic [TAG_BITS-1:0]        rd_tag;
	logic [`BTB_INDEX_BITS-1:0] wr_index;
	logic [TAG_BITS-1:0]        wr_tag;
	logic                       wr_hit;  // update pc already has an entry

	//////////////////////////////
	// lookup, combinational
	//////////////////////////////

	assign rd_index = btb_request.pc[`BTB_INDEX_BITS+1:2];
	assign rd_tag   = btb_request.pc[`XLEN-1:`BTB_INDEX_BITS+2];

	always_comb begin
		btb_lookup.valid      = btb_request.valid && entry_valid[rd_index] &&
			(entry_tag[rd_index] == rd_tag);
		btb_lookup.prediction = entry_count[rd_index][1]; // weakly/strongly taken
		btb_lookup.target_pc  = entry_target[rd_index];
	end

	//////////////////////////////
	// retire update
	//////////////////////////////

	assign wr_index = btb_update.pc[`BTB_INDEX_BITS+1:2];
	assign wr_tag   = btb_update.pc[`XLEN-1:`BTB_INDEX_BITS+2];
	assign wr_hit   = entry_valid[wr_index] && (entry_tag[wr_index] == wr_tag);

	// entry valid bits, set when a taken miss allocates
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < ENTRIES; i++) begin
				entry_valid[i] <= 1'b0;
			end
		end else if (btb_update.valid && !wr_hit && btb_update.taken) begin
			entry_valid[wr_index] <= 1'b1; // allocate on first taken
		end
	end

	// counters, tags and targets
	always_ff @(posedge clock) begin
		if (btb_update.valid) begin
			if (wr_hit) begin
				if (btb_update.taken) begin
					if (entry_count[wr_index] != 2'b11) begin
						entry_count[wr_index] <= entry_count[wr_index] + 2'b01; // count up
					end
					entry_target[wr_index] <= btb_update.target_pc; // target may have moved
				end else if (entry_count[wr_index] != 2'b00) begin
					entry_count[wr_index] <= entry_count[wr_index] - 2'b01;     // count down
				end
			end else if (btb_update.taken) begin
				// new entry starts weakly taken
				entry_tag[wr_index]    <= wr_tag;
				entry_target[wr_index] <= btb_update.target_pc;
				entry_count[wr_index]  <= 2'b10;
			end
			// not-taken miss leaves the table alone
		end
	end

endmodule

`default_nettype wire

/* design/instruction_cache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module instruction_cache import fetch_pkg::*; (
	input  wire logic             clock,
	input  wire logic             reset,
	input  wire logic [`XLEN-1:0] icache_addr,  // block aligned fetch address
	input  wire mem_response_t    mem_response,
	output logic [`BLOCK_BITS-1:0] icache_data,
	output logic                   icache_hit,
	output mem_request_t           mem_request
);

	localparam int BLOCKS   = 1 << `ICACHE_INDEX_BITS;
	localparam int TAG_BITS = `XLEN - `ICACHE_INDEX_BITS - 3; // 8-byte blocks

	// refill machine, one miss in flight
	typedef enum logic {
		refill_idle,
		refill_wait
	} refill_state_t;

	refill_state_t state;

	logic                   line_valid [BLOCKS];
	logic [TAG_BITS-1:0]    line_tag   [BLOCKS];
	logic [`BLOCK_BITS-1:0] line_data  [BLOCKS];

	logic [`ICACHE_INDEX_BITS-1:0] rd_index;
	logic [TAG_BITS-1:0]           rd_tag;
	logic [`ICACHE_INDEX_BITS-1:0] fill_index; // block named by the request
	logic [TAG_BITS-1:0]           fill_tag;

	logic             req_valid;   // request strobe
	logic [`XLEN-1:0] req_addr;    // missed block, held until the response

	//////////////////////////////
	// read side
	//////////////////////////////

	assign rd_index = icache_addr[`ICACHE_INDEX_BITS+2:3];
	assign rd_tag   = icache_addr[`XLEN-1:`ICACHE_INDEX_BITS+3];

	assign icache_hit  = line_valid[rd_index] && (line_tag[rd_index] == rd_tag);
	assign icache_data = line_data[rd_index];

	//////////////////////////////
	// refill
	//////////////////////////////

	assign fill_index = req_addr[`ICACHE_INDEX_BITS+2:3];
	assign fill_tag   = req_addr[`XLEN-1:`ICACHE_INDEX_BITS+3];

	assign mem_request.valid = req_valid;
	assign mem_request.addr  = req_addr;

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= refill_idle;
			req_valid <= 1'b0;
		end else begin
			req_valid <= 1'b0; // strobe lasts one cycle
			case (state)
				refill_idle: begin
					if (!icache_hit) begin
						state     <= refill_wait;
						req_valid <= 1'b1;   // goes out the cycle after the miss
					end
				end
				refill_wait: begin
					if (mem_response.valid) begin
						state <= refill_idle; // block lands this edge
					end
				end
				default: state <= refill_idle;
			endcase
		end
	end

	// address latched together with the request strobe
	always_ff @(posedge clock) begin
		if (state == refill_idle && !icache_hit) begin
			req_addr <= {icache_addr[`XLEN-1:3], 3'b000};
		end
	end

	// valid bits
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < BLOCKS; i++) begin
				line_valid[i] <= 1'b0;
			end
		end else if (state == refill_wait && mem_response.valid) begin
			line_valid[fill_index] <= 1'b1;
		end
	end

	// tag and data write, always to the requested block even after a squash
	always_ff @(posedge clock) begin
		if (state == refill_wait && mem_response.valid) begin
			line_tag[fill_index]  <= fill_tag;
			line_data[fill_index] <= mem_response.data;
		end
	end

endmodule

`default_nettype wire

/* design/fetch_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_queue import fetch_pkg::*; (
	input  wire logic          clock,
	input  wire logic          reset,
	input  wire logic          squash,      // flush everything
	input  wire if_id_packet_t push_packet, // pushed when its valid bit is set
	input  wire logic          decode_pop,  // pulse from decode
	output if_id_packet_t      head_packet,
	output logic               full
);

	localparam int DEPTH     = `FETCH_QUEUE_DEPTH;
	localparam int PTR_BITS  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS  = $clog2(DEPTH + 1);

	if_id_packet_t entries [DEPTH]; // packet storage

	logic [PTR_BITS-1:0] head_ptr;
	logic [PTR_BITS-1:0] tail_ptr;
	logic [CNT_BITS-1:0] count;

	logic empty;
	logic do_push;
	logic do_pop;

	assign empty = (count == '0);
	assign full  = (count == CNT_BITS'(DEPTH));

	assign do_pop  = decode_pop && !empty;               // pop on empty is dropped
	assign do_push = push_packet.valid && (!full || do_pop); // full queue takes a push with a pop

	// head view, valid only when something is stored
	always_comb begin
		head_packet       = entries[head_ptr];
		head_packet.valid = !empty;
	end

	//////////////////////////////
	// pointers and count
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset || squash) begin
			head_ptr <= '0;
			tail_ptr <= '0;
			count    <= '0;
		end else begin
			if (do_push) begin
				tail_ptr <= (tail_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : tail_ptr + 1'b1;
			end
			if (do_pop) begin
				head_ptr <= (head_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : head_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	// storage write, a squash drops the push of that cycle
	always_ff @(posedge clock) begin
		if (do_push && !squash) begin
			entries[tail_ptr] <= push_packet;
		end
	end

endmodule

`default_nettype wire

/* design/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_top import fetch_pkg::*; (
	input  wire logic             clock,
	input  wire logic             reset,
	input  wire logic             squash,       // retire redirect
	input  wire logic [`XLEN-1:0] rt_npc,
	input  wire mem_command_t     dmem_command,
	input  wire btb_update_t      btb_update,   // resolved branches
	input  wire mem_response_t    mem_response, // refill data
	input  wire logic             decode_pop,
	output mem_request_t          mem_request,
	output if_id_packet_t         decode_packet // queue head
);

	//////////////////////////////
	// internal nets
	//////////////////////////////

	logic [`XLEN-1:0]       icache_addr;
	logic [`BLOCK_BITS-1:0] icache_data;
	logic                   icache_hit;
	logic                   queue_full;  // stall into fetch
	if_id_packet_t          if_packet;
	fetch_btb_t             btb_request;
	btb_lookup_t            btb_lookup;

	fetch_stage fetch_stage_inst (
		.clock        (clock),
		.reset        (reset),
		.squash       (squash),
		.rt_npc       (rt_npc),
		.stall        (queue_full),
		.dmem_command (dmem_command),
		.icache_data  (icache_data),
		.icache_hit   (icache_hit),
		.btb_lookup   (btb_lookup),
		.icache_addr  (icache_addr),
		.if_packet    (if_packet),
		.btb_request  (btb_request)
	);

	branch_target_buffer branch_target_buffer_inst (
		.clock       (clock),
		.reset       (reset),
		.btb_request (btb_request),
		.btb_update  (btb_update),
		.btb_lookup  (btb_lookup)
	);

	instruction_cache instruction_cache_inst (
		.clock        (clock),
		.reset        (reset),
		.icache_addr  (icache_addr),
		.mem_response (mem_response),
		.icache_data  (icache_data),
		.icache_hit   (icache_hit),
		.mem_request  (mem_request)
	);

	fetch_queue fetch_queue_inst (
		.clock       (clock),
		.reset       (reset),
		.squash      (squash),
		.push_packet (if_packet),
		.decode_pop  (decode_pop),
		.head_packet (decode_packet),
		.full        (queue_full)
	);

endmodule

`default_nettype wire

/* testbench/fetch_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_clock_gen #(
	parameter int PERIOD_NS    = 4,
	parameter int RESET_CYCLES = 2
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD_NS / 2) clock = ~clock;
	end

	// reset drops 1 ns after the last reset edge, like the other inputs
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		#1 reset = 1'b0;
	end

endmodule

`default_nettype wire

/* testbench/fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_tb import fetch_pkg::*; ();

	localparam int PERIOD_NS     = 4;
	localparam int MAX_LATENCY   = 6;                     // memory answers 1 to 6 cycles late
	localparam int PACKET_CYCLES = (MAX_LATENCY + 3) * 4; // refill plus back-pressure, per packet
	localparam int BRANCH_ROUNDS = 24;
	localparam int SQUASH_ROUNDS = 30;
	localparam int TOTAL_PACKETS = 1 + 200 + BRANCH_ROUNDS * 6 + SQUASH_ROUNDS * 8 + 4 + 200;
	localparam int WATCHDOG_NS   = (TOTAL_PACKETS * PACKET_CYCLES * 2 + 2000) * PERIOD_NS;
	localparam int BTB_ENTRIES   = 1 << `BTB_INDEX_BITS;

	logic             clock;
	logic             reset;
	logic             squash;
	logic [`XLEN-1:0] rt_npc;
	mem_command_t     dmem_command;
	btb_update_t      btb_update;
	mem_response_t    mem_response;
	logic             decode_pop;
	mem_request_t     mem_request;
	if_id_packet_t    decode_packet;

	// target buffer model, trained by the same updates as the DUT
	bit               model_valid  [BTB_ENTRIES];
	logic [`XLEN-1:0] model_tag    [BTB_ENTRIES];
	logic [`XLEN-1:0] model_target [BTB_ENTRIES];
	int               model_count  [BTB_ENTRIES];

	logic [`XLEN-1:0] expected_pc;   // pc of the next packet decode should see
	bit               mem_pending;   // refill in flight in the memory model
	int               mem_wait;
	logic [`XLEN-1:0] mem_addr;

	int error_count;
	int check_count;
	int error_mark;
	int check_mark;
	int tests_run;
	int taken_hits;      // popped packets whose pc had a taken entry
	int not_taken_hits;
	int flushed_count;   // squashes that hit a non-empty queue

	fetch_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(2)) fetch_clock_gen_inst (
		.clock (clock),
		.reset (reset)
	);

	fetch_top fetch_top_inst (
		.clock         (clock),
		.reset         (reset),
		.squash        (squash),
		.rt_npc        (rt_npc),
		.dmem_command  (dmem_command),
		.btb_update    (btb_update),
		.mem_response  (mem_response),
		.decode_pop    (decode_pop),
		.mem_request   (mem_request),
		.decode_packet (decode_packet)
	);

	//////////////////////////////
	// reference models
	//////////////////////////////

	// instruction word stored at a byte address, mixes every address bit
	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		logic [31:0] h;
		h = addr ^ 32'h5bd1e995;
		h = h * 32'h01000193;
		h = h ^ (h >> 13);
		return h;
	endfunction

	function automatic bit model_hit(input logic [`XLEN-1:0] pc);
		int idx;
		idx = int'(pc[`BTB_INDEX_BITS+1:2]); // index above the word offset
		return model_valid[idx] && (model_tag[idx] == (pc >> (`BTB_INDEX_BITS + 2)));
	endfunction

	function automatic logic [`XLEN-1:0] model_npc(input logic [`XLEN-1:0] pc);
		int idx;
		idx = int'(pc[`BTB_INDEX_BITS+1:2]);
		if (model_hit(pc) && model_count[idx] >= 2) return model_target[idx]; // high bit set
		return pc + 4;
	endfunction

	task automatic model_update(input logic [`XLEN-1:0] pc, input bit taken,
			input logic [`XLEN-1:0] target);
		int idx;
		idx = int'(pc[`BTB_INDEX_BITS+1:2]);
		if (model_hit(pc)) begin
			if (taken) begin
				if (model_count[idx] < 3) model_count[idx]++;
				model_target[idx] = target;
			end else if (model_count[idx] > 0) begin
				model_count[idx]--;
			end
		end else if (taken) begin
			model_valid[idx]  = 1'b1; // allocate weakly taken
			model_tag[idx]    = pc >> (`BTB_INDEX_BITS + 2);
			model_target[idx] = target;
			model_count[idx]  = 2;
		end
	endtask

	// external memory, one refill at a time
	task automatic serve_memory();
		mem_response.valid = 1'b0;
		if (mem_pending) begin
			if (mem_wait == 0) begin
				mem_response.valid = 1'b1;
				mem_response.data  = {mem_word(mem_addr + 4), mem_word(mem_addr)};
				mem_pending        = 1'b0;
			end else begin
				mem_wait--;
			end
		end
		if (mem_request.valid) begin
			if (mem_pending) begin
				error_count++;
				$display("memory request arrived while a refill was still outstanding");
			end
			if (mem_request.addr[2:0] !== 3'b000) begin
				error_count++;
				$display("ERROR mem_request.addr[2:0]: got %h expected %h",
					mem_request.addr[2:0], 3'b000);
			end
			mem_pending = 1'b1;
			mem_addr    = {mem_request.addr[`XLEN-1:3], 3'b000};
			mem_wait    = $urandom_range(0, MAX_LATENCY - 1); // 1 to MAX_LATENCY cycles
		end
	endtask

	//////////////////////////////
	// stimulus helpers
	//////////////////////////////

	// next cycle, inputs back to idle 1 ns after the edge
	task automatic tick();
		@(posedge clock);
		#1;
		squash            = 1'b0;
		decode_pop        = 1'b0;
		dmem_command      = bus_none;
		btb_update.valid  = 1'b0;
		serve_memory();
	endtask

	task automatic check_head();
		if_id_packet_t    pkt;
		logic [`XLEN-1:0] exp_npc;
		pkt     = decode_packet;
		exp_npc = model_npc(pkt.pc);
		if (pkt.pc !== expected_pc) begin
			error_count++;
			$display("ERROR decode_packet.pc: got %h expected %h", pkt.pc, expected_pc);
		end
		if (pkt.inst !== mem_word(pkt.pc)) begin
			error_count++;
			$display("ERROR decode_packet.inst: got %h expected %h", pkt.inst, mem_word(pkt.pc));
		end
		if (pkt.npc !== exp_npc) begin
			error_count++;
			$display("ERROR decode_packet.npc: got %h expected %h", pkt.npc, exp_npc);
		end
		if (model_hit(pkt.pc)) begin
			if (model_count[int'(pkt.pc[`BTB_INDEX_BITS+1:2])] >= 2) taken_hits++;
			else not_taken_hits++;
		end
		check_count += 3;
		expected_pc = exp_npc; // stream follows the prediction
	endtask

	// pop and check until count packets reached decode
	task automatic run_packets(input int count, input int pop_pct, input int busy_pct);
		int got;
		int cycles;
		got    = 0;
		cycles = 0;
		while (got < count && cycles < count * PACKET_CYCLES + 50) begin
			tick();
			if ($urandom_range(0, 99) < busy_pct) begin
				dmem_command = ($urandom_range(0, 1) == 0) ? bus_load : bus_store;
			end
			if ($urandom_range(0, 99) < pop_pct) begin
				decode_pop = 1'b1; // may hit an empty queue
				if (decode_packet.valid) begin
					check_head();
					got++;
				end
			end
			cycles++;
		end
		if (got < count) begin
			error_count++;
			$display("timeout: only %0d of %0d packets reached decode", got, count);
		end
	endtask

	task automatic train_branch(input logic [`XLEN-1:0] pc, input bit taken,
			input logic [`XLEN-1:0] target);
		tick();
		btb_update.valid     = 1'b1;
		btb_update.pc        = pc;
		btb_update.taken     = taken;
		btb_update.target_pc = target;
		model_update(pc, taken, target);
	endtask

	task automatic redirect(input logic [`XLEN-1:0] target);
		tick();
		if (decode_packet.valid) flushed_count++;
		squash      = 1'b1;
		rt_npc      = target;
		expected_pc = target; // queued packets are dropped
	endtask

	task automatic start_test();
		error_mark = error_count;
		check_mark = check_count;
	endtask

	task automatic end_test(input int num, input string name);
		int errs;
		errs = error_count - error_mark;
		tests_run++;
		$display("test %0d %s: %0d checks, %0d errors, %s", num, name,
			check_count - check_mark, errs, (errs == 0) ? "ok" : "FAILED");
	endtask

	//////////////////////////////
	// test sequence
	//////////////////////////////

	initial begin
		logic [`XLEN-1:0] bp;
		logic [`XLEN-1:0] tp;
		int               n_upd;
		void'($urandom(32'hdc46be7d));
		squash       = 1'b0;
		rt_npc       = '0;
		dmem_command = bus_none;
		btb_update   = '0;
		mem_response = '0;
		decode_pop   = 1'b0;
		expected_pc  = '0; // boot pc
		mem_pending  = 1'b0;
		mem_wait     = 0;
		mem_addr     = '0;
		for (int i = 0; i < BTB_ENTRIES; i++) begin
			model_valid[i] = 1'b0;
			model_count[i] = 0;
		end
		@(negedge reset);

		start_test();
		if (decode_packet.valid !== 1'b0) begin
			error_count++;
			$display("ERROR decode_packet.valid: got %h expected 0", decode_packet.valid);
		end
		if (mem_request.valid !== 1'b0) begin
			error_count++;
			$display("ERROR mem_request.valid: got %h expected 0", mem_request.valid);
		end
		check_count += 2;
		run_packets(1, 100, 0); // first packet must come from pc 0
		end_test(1, "reset");

		start_test();
		run_packets(200, 80, 0);
		end_test(2, "sequential fetch");

		// train a branch, then restart two words before it
		start_test();
		for (int r = 0; r < BRANCH_ROUNDS; r++) begin
			bp    = 32'h2000 + ($urandom_range(0, 31) << 2); // some pairs share an index
			tp    = 32'h3000 + ($urandom_range(0, 255) << 2);
			n_upd = $urandom_range(1, 3);
			for (int k = 0; k < n_upd; k++) begin
				train_branch(bp, ($urandom_range(0, 1) == 1), tp);
			end
			redirect(bp - 8);
			run_packets(6, 70, 10);
		end
		if (taken_hits == 0 || not_taken_hits == 0) begin
			error_count++;
			$display("branch test never saw both a taken and a not-taken entry at a fetched pc");
		end
		end_test(3, "branch prediction");

		start_test();
		for (int r = 0; r < SQUASH_ROUNDS; r++) begin
			run_packets($urandom_range(1, 8), 70, 0);
			repeat ($urandom_range(0, 6)) tick(); // let stale packets pile up
			redirect($urandom_range(0, 4095) << 2);
		end
		run_packets(4, 70, 0);
		if (flushed_count == 0) begin
			error_count++;
			$display("no squash found packets waiting in the queue");
		end
		end_test(4, "squash");

		start_test();
		run_packets(200, 30, 30); // slow decode and a busy data bus
		end_test(5, "back-pressure");

		$display("summary: %0d tests, %0d checks, %0d errors", tests_run, check_count,
			error_count);
		if (error_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+design
design/fetch_pkg.sv
design/fetch_stage.sv
design/branch_target_buffer.sv
design/instruction_cache.sv
design/fetch_queue.sv
design/fetch_top.sv
testbench/fetch_clock_gen.sv
testbench/fetch_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module fetch_tb -f all.f -o fetch_sim \
	> build.log 2>&1 || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/fetch_sim > sim.log 2>&1
cat sim.log

grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log && exit 0 || exit 1
